// File: common/tensor_issue_config.svh
`ifndef TENSOR_ISSUE_CONFIG_SVH
`define TENSOR_ISSUE_CONFIG_SVH

// warp geometry
`define NUM_THREADS      4
`define NUM_WARPS        4

// datapath widths
`define XLEN             32
// register number, top bit selects the float file
`define NR_BITS          6
`define UUID_WIDTH       8

// issue buffering and flow control
`define IBUF_DEPTH       4
`define ISSUE_CREDITS    4

// accumulator bank offset applied when rd index is 1
`define ACC_OFFSET_RESET 8

// microcode address, 32 entries
`define UPC_BITS         5

`endif

// File: common/tensor_issue_pkg.sv
`include "tensor_issue_config.svh"

package tensor_issue_pkg;

    localparam int WID_BITS     = $clog2(`NUM_WARPS);
    localparam int OP_TYPE_BITS = 4;
    localparam int OP_MOD_BITS  = 3;
    // register index without the float-file bit
    localparam int REG_IDX_BITS = `NR_BITS - 1;

    typedef enum logic [1:0] {
        EX_ALU    = 2'd0,
        EX_LSU    = 2'd1,
        EX_FPU    = 2'd2,
        EX_TENSOR = 2'd3
    } ex_type_e;

    typedef logic [`NR_BITS-1:0] reg_num_t;

    // decoded instruction as seen by the issue stage
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]  uuid;
        logic [WID_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic                    wb;
        logic                    use_pc;
        logic                    use_imm;
        logic [`XLEN-1:0]        imm;
        ex_type_e                ex_type;
        logic [OP_TYPE_BITS-1:0] op_type;
        logic [OP_MOD_BITS-1:0]  op_mod;
        reg_num_t                rd;
        reg_num_t                rs1;
        reg_num_t                rs2;
        reg_num_t                rs3;
    } instr_data_t;

    // one microcode word, the rest of the micro-op comes from the parent instruction
    typedef struct packed {
        logic                    last;
        logic [OP_TYPE_BITS-1:0] op_type;
        logic [OP_MOD_BITS-1:0]  op_mod;
        reg_num_t                rd;
        reg_num_t                rs1;
        reg_num_t                rs2;
        reg_num_t                rs3;
    } uop_entry_t;

    // float register with the given index
    function automatic reg_num_t freg(input logic [REG_IDX_BITS-1:0] idx);
        return {1'b1, idx};
    endfunction

endpackage

// File: common/instr_stream_if.sv
// instruction stream with a valid/ready handshake
// a transfer happens when valid and ready are both high;
// valid and data are held by the producer until then
interface instr_stream_if import tensor_issue_pkg::*; ();

    logic        valid;
    logic        ready;
    instr_data_t data;

    modport producer (
        output valid,
        output data,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: uop_sequencer/uop_rom.sv
`include "tensor_issue_config.svh"

// microcode table for the tensor mma expansion
// register layout: A in f0-f7, B in f8-f15, accumulators in f16-f23
module uop_rom import tensor_issue_pkg::*; (
    input  logic [`UPC_BITS-1:0] upc,
    output uop_entry_t           entry
);

    localparam int SET_BITS = `UPC_BITS - 3;

    logic [SET_BITS-1:0] set_idx;
    logic [1:0]          step;
    logic                half;
    // position inside one operand set, selects the accumulator
    logic [2:0]          acc_idx;
    logic [REG_IDX_BITS-1:0] a_idx;
    logic [REG_IDX_BITS-1:0] b_idx;
    logic [REG_IDX_BITS-1:0] c_idx;

    assign set_idx = upc[`UPC_BITS-1:3];
    assign step    = upc[2:1];
    assign half    = upc[0];
    assign acc_idx = upc[2:0];

    // each set uses a pair of A and B registers, the half picks one of the pair
    assign a_idx = REG_IDX_BITS'({set_idx, half});
    assign b_idx = REG_IDX_BITS'(8) + REG_IDX_BITS'({set_idx, half});
    assign c_idx = REG_IDX_BITS'(16) + REG_IDX_BITS'(acc_idx);

    always_comb begin
        entry.op_type = OP_TYPE_BITS'(step);
        entry.op_mod  = OP_MOD_BITS'(half);
        entry.rd      = freg(c_idx);
        entry.rs1     = freg(a_idx);
        entry.rs2     = freg(b_idx);
        // accumulate in place
        entry.rs3     = freg(c_idx);
        entry.last    = (upc == `UPC_BITS'(31));
    end

endmodule

// File: uop_sequencer/uop_sequencer.sv
`include "tensor_issue_config.svh"

// expands tensor instructions into a fixed sequence of register-level micro-ops,
// all other instructions go straight through
module uop_sequencer import tensor_issue_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             uop_enable,
    input  reg_num_t         acc_offset,
    instr_stream_if.consumer dec,
    instr_stream_if.producer out
);

    logic [`UPC_BITS-1:0] upc;
    uop_entry_t           entry;
    logic                 expand;
    logic                 out_fire;
    logic                 acc_bank;
    instr_data_t          uop;

    uop_rom uop_rom_i (
        .upc   (upc),
        .entry (entry)
    );

    assign expand   = dec.valid && (dec.data.ex_type == EX_TENSOR) && uop_enable;
    assign out_fire = out.valid && out.ready;

    // rd index 1 selects the second accumulator bank
    assign acc_bank = (dec.data.rd[REG_IDX_BITS-1:0] == REG_IDX_BITS'(1));

    always_comb begin
        // tag and thread state come from the parent instruction
        uop.uuid    = dec.data.uuid;
        uop.wid     = dec.data.wid;
        uop.tmask   = dec.data.tmask;
        uop.pc      = dec.data.pc;
        uop.wb      = 1'b1;
        uop.use_pc  = 1'b0;
        uop.use_imm = 1'b0;
        uop.imm     = '0;
        uop.ex_type = EX_TENSOR;
        uop.op_type = entry.op_type;
        uop.op_mod  = entry.op_mod;
        uop.rd      = entry.rd;
        uop.rs1     = entry.rs1;
        uop.rs2     = entry.rs2;
        uop.rs3     = entry.rs3;

        if (acc_bank) begin
            uop.rd  = entry.rd + acc_offset;
            uop.rs3 = entry.rs3 + acc_offset;
        end
    end

    // while expanding the input is held, so valid simply follows it
    assign out.valid = dec.valid;
    assign out.data  = expand ? uop : dec.data;

    // parent instruction is consumed together with its final micro-op
    assign dec.ready = expand ? (out.ready && entry.last) : out.ready;

    // micro-PC sits at 0 between expansions
    always_ff @(posedge clk) begin
        if (reset) begin
            upc <= '0;
        end else if (!expand) begin
            upc <= '0;
        end else if (out_fire) begin
            if (entry.last) begin
                upc <= '0;
            end else begin
                upc <= upc + 1'b1;
            end
        end
    end

endmodule

// File: source/seq_ctrl_regs.sv
`include "tensor_issue_config.svh"

// sequencer control registers
// addr 0 bit 0 enables microcode, addr 1 holds the accumulator bank offset
module seq_ctrl_regs import tensor_issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_write,
    input  logic                cfg_addr,
    input  logic [`NR_BITS-1:0] cfg_wdata,
    output logic                uop_enable,
    output reg_num_t            acc_offset
);

    logic enable_we;
    logic offset_we;

    assign enable_we = cfg_write && (cfg_addr == 1'b0);
    assign offset_we = cfg_write && (cfg_addr == 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            uop_enable <= 1'b1;
            acc_offset <= `NR_BITS'(`ACC_OFFSET_RESET);
        end else begin
            if (enable_we) begin
                uop_enable <= cfg_wdata[0];
            end
            if (offset_we) begin
                acc_offset <= cfg_wdata;
            end
        end
    end

endmodule

// File: source/instr_buffer.sv
`include "tensor_issue_config.svh"

// micro-op FIFO in front of the scheduler
// issue is gated by credits the scheduler hands back one pulse at a time
module instr_buffer import tensor_issue_pkg::*; #(
    parameter int DEPTH = `IBUF_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_credit,
    instr_stream_if.consumer enq,
    output logic             issue_valid,
    output instr_data_t      issue_data
);

    localparam int PTR_BITS    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS    = $clog2(DEPTH + 1);
    localparam int CREDIT_BITS = $clog2(`ISSUE_CREDITS + 1);

    instr_data_t            mem [DEPTH];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;
    logic [CREDIT_BITS-1:0] credits;
    logic                   enq_fire;

    // wrap works for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign enq.ready   = (count != CNT_BITS'(DEPTH));
    assign enq_fire    = enq.valid && enq.ready;
    assign issue_valid = (count != '0) && (credits != '0);
    assign issue_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CREDIT_BITS'(`ISSUE_CREDITS);
        end else begin
            if (enq_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end

            case ({enq_fire, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // an issue and a returned credit in the same cycle cancel out
            case ({issue_credit, issue_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: source/tensor_issue_front.sv
`include "tensor_issue_config.svh"

// issue front end: control registers, micro-op sequencer and issue buffer
module tensor_issue_front import tensor_issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  instr_data_t         in_data,
    output logic                in_ready,
    input  logic                issue_credit,
    output logic                issue_valid,
    output instr_data_t         issue_data,
    input  logic                cfg_write,
    input  logic                cfg_addr,
    input  logic [`NR_BITS-1:0] cfg_wdata
);

    logic     uop_enable;
    reg_num_t acc_offset;

    instr_stream_if dec_if ();
    instr_stream_if uop_if ();

    // decoded input stream
    assign dec_if.valid = in_valid;
    assign dec_if.data  = in_data;
    assign in_ready     = dec_if.ready;

    seq_ctrl_regs seq_ctrl_regs_i (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .uop_enable (uop_enable),
        .acc_offset (acc_offset)
    );

    uop_sequencer uop_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .uop_enable (uop_enable),
        .acc_offset (acc_offset),
        .dec        (dec_if.consumer),
        .out        (uop_if.producer)
    );

    instr_buffer #(
        .DEPTH (`IBUF_DEPTH)
    ) instr_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .issue_credit (issue_credit),
        .enq          (uop_if.consumer),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data)
    );

endmodule

// File: testbench/tb_tensor_issue_front.sv
`include "tensor_issue_config.svh"

module tb_tensor_issue_front import tensor_issue_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTRS     = 60;
    localparam int UOPS_PER_MMA   = 32;
    localparam int TIMEOUT_CYCLES = NUM_INSTRS * UOPS_PER_MMA * 4 + 500;

    logic                clk;
    logic                reset;
    logic                in_valid;
    instr_data_t         in_data;
    logic                in_ready;
    logic                issue_credit;
    logic                issue_valid;
    instr_data_t         issue_data;
    logic                cfg_write;
    logic                cfg_addr;
    logic [`NR_BITS-1:0] cfg_wdata;

    // reference model state
    instr_data_t exp_q[$];
    string       exp_name_q[$];
    logic        model_enable;
    reg_num_t    model_offset;
    int          pushed_total;
    int          issued_total;
    // issues the consumer holds without having returned the credit
    int          in_use;
    logic        sparse_credits;

    logic [15:0] lfsr_state;
    int          value_errors;
    int          protocol_errors;
    int          cycle_count;

    tensor_issue_front tensor_issue_front_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_ready     (in_ready),
        .issue_credit (issue_credit),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // feedback polynomial x^16 + x^14 + x^13 + x^11 + 1
    // stepped once for every bit returned
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        int          b;
        value = '0;
        for (b = 0; b < n; b++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // advance to just after the next rising edge and drive the credit return
    task automatic step_cycle();
        logic give;
        @(posedge clk);
        #2;
        if (sparse_credits) begin
            give = (rand_bits(2) == 0);
        end else begin
            give = rand_bits(1);
        end
        issue_credit = give && (in_use > 0);
    endtask

    // expected issue stream for one accepted instruction
    task automatic push_expected(input instr_data_t instr, input int idx);
        instr_data_t u;
        int          k;
        if (instr.ex_type == EX_TENSOR && model_enable) begin
            for (k = 0; k < UOPS_PER_MMA; k++) begin
                u         = instr;
                u.wb      = 1'b1;
                u.use_pc  = 1'b0;
                u.use_imm = 1'b0;
                u.imm     = '0;
                u.ex_type = EX_TENSOR;
                u.op_type = 4'((k % 8) / 2);
                u.op_mod  = 3'(k % 2);
                // accumulators in f16-f23 and one A and B pair per operand set
                u.rd      = {1'b1, 5'(16 + k % 8)};
                u.rs3     = u.rd;
                u.rs1     = {1'b1, 5'(2 * (k / 8) + k % 2)};
                u.rs2     = {1'b1, 5'(8 + 2 * (k / 8) + k % 2)};
                if (instr.rd[4:0] == 5'd1) begin
                    u.rd  = u.rd + model_offset;
                    u.rs3 = u.rs3 + model_offset;
                end
                exp_q.push_back(u);
                exp_name_q.push_back($sformatf("instr %0d uop %0d", idx, k));
                pushed_total++;
            end
        end else begin
            exp_q.push_back(instr);
            exp_name_q.push_back($sformatf("instr %0d passthrough", idx));
            pushed_total++;
        end
    endtask

    task automatic write_cfg(input logic addr, input logic [`NR_BITS-1:0] wdata);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        step_cycle();
        cfg_write = 1'b0;
        if (addr) begin
            model_offset = wdata;
        end else begin
            model_enable = wdata[0];
        end
    endtask

    task automatic send_instr(input instr_data_t instr, input int idx);
        int   waited;
        logic expanded;
        waited   = 0;
        expanded = (instr.ex_type == EX_TENSOR) && model_enable;
        push_expected(instr, idx);
        in_valid = 1'b1;
        in_data  = instr;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            step_cycle();
            @(negedge clk);
        end
        if (expanded && waited < UOPS_PER_MMA - 1) begin
            $display("instr %0d: in_ready rose after only %0d cycles of expansion",
                     idx, waited);
            protocol_errors++;
        end
        step_cycle();
        in_valid = 1'b0;
        // every micro-op of the accepted instruction must now sit in the buffer or be issued
        if (pushed_total - issued_total > `IBUF_DEPTH) begin
            $display("instr %0d accepted while %0d micro-ops were still unbuffered",
                     idx, pushed_total - issued_total - `IBUF_DEPTH);
            protocol_errors++;
        end
    endtask

    // issue monitor samples mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (issue_valid) begin
                if (in_use >= `ISSUE_CREDITS) begin
                    $display("issue with no credits left, %0d outstanding", in_use);
                    protocol_errors++;
                end
                in_use++;
                issued_total++;
                if (exp_q.size() == 0) begin
                    $display("unexpected issue with uuid %h, nothing left to issue",
                             issue_data.uuid);
                    protocol_errors++;
                end else begin
                    check_value(exp_name_q.pop_front(), exp_q.pop_front(), issue_data);
                end
            end
            if (issue_credit) begin
                in_use--;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d issues still expected",
                 cycle_count, exp_q.size());
        protocol_errors++;
        finish_run();
    end

    initial begin
        instr_data_t instr;
        int          i;
        logic        force_bank;
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_data         = '0;
        issue_credit    = 1'b0;
        cfg_write       = 1'b0;
        cfg_addr        = 1'b0;
        cfg_wdata       = '0;
        lfsr_state      = 16'd68;
        model_enable    = 1'b1;
        model_offset    = `NR_BITS'(`ACC_OFFSET_RESET);
        pushed_total    = 0;
        issued_total    = 0;
        in_use          = 0;
        sparse_credits  = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;

        repeat (8) step_cycle();
        reset = 1'b0;
        @(negedge clk);
        check_value("issue_valid after reset", 0, issue_valid);
        step_cycle();

        for (i = 0; i < NUM_INSTRS; i++) begin
            // config changes only between instructions
            // each new offset differs from the one before it
            if (i == 20) begin
                write_cfg(1'b1, `NR_BITS'(rand_bits(2) + 1));
            end else if (i == 35) begin
                write_cfg(1'b0, '0);
            end else if (i == 45) begin
                write_cfg(1'b0, `NR_BITS'(1));
            end else if (i == 50) begin
                write_cfg(1'b1, `NR_BITS'(rand_bits(2) + 5));
            end
            sparse_credits = (i >= 20 && i < 35);
            // right after an offset or enable change comes a tensor op on the second bank
            force_bank = (i == 20 || i == 35 || i == 50);

            repeat (rand_bits(2)) step_cycle();

            instr.uuid    = 8'(i);
            instr.wid     = WID_BITS'(rand_bits(WID_BITS));
            instr.tmask   = `NUM_THREADS'(rand_bits(`NUM_THREADS));
            instr.pc      = rand_bits(32);
            instr.wb      = rand_bits(1);
            instr.use_pc  = rand_bits(1);
            instr.use_imm = rand_bits(1);
            instr.imm     = rand_bits(32);
            instr.op_type = 4'(rand_bits(4));
            instr.op_mod  = 3'(rand_bits(3));
            instr.rs1     = reg_num_t'(rand_bits(`NR_BITS));
            instr.rs2     = reg_num_t'(rand_bits(`NR_BITS));
            instr.rs3     = reg_num_t'(rand_bits(`NR_BITS));
            if (i == 0 || force_bank || rand_bits(5) < 13) begin
                instr.ex_type = EX_TENSOR;
            end else begin
                instr.ex_type = ex_type_e'(rand_bits(2) % 3);
            end
            // half of the tensor instructions select the second accumulator bank
            if (instr.ex_type == EX_TENSOR && (force_bank || rand_bits(1))) begin
                instr.rd = {rand_bits(1) != 0, 5'd1};
            end else begin
                instr.rd = reg_num_t'(rand_bits(`NR_BITS));
            end
            send_instr(instr, i);
        end

        sparse_credits = 1'b0;
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        // a few more cycles to catch stray issues
        repeat (10) step_cycle();
        finish_run();
    end

endmodule

// File: flist.f
+incdir+common
common/tensor_issue_pkg.sv
common/instr_stream_if.sv
uop_sequencer/uop_rom.sv
uop_sequencer/uop_sequencer.sv
source/seq_ctrl_regs.sv
source/instr_buffer.sv
source/tensor_issue_front.sv
testbench/tb_tensor_issue_front.sv
